// File: isaPkg.sv
// ========================================
// Accumulator CPU instruction set
// Opcode encodings, ALU operation codes and
// the status word with its two views
// ========================================
package isaPkg;

	typedef enum logic [7:0] {
		// Immediate operand
		opLdaImm = 8'h10,
		opAddImm = 8'h11,
		opSubImm = 8'h12,
		opAndImm = 8'h13,
		opOraImm = 8'h14,
		// Absolute address, low byte first
		opLdaAbs = 8'h20,
		opAddAbs = 8'h21,
		opSubAbs = 8'h22,
		opAndAbs = 8'h23,
		opOraAbs = 8'h24,
		opStaAbs = 8'h25,
		opJmpAbs = 8'h26,
		// Relative branches, signed offset byte
		opBcc    = 8'h30,
		opBcs    = 8'h31,
		opBeq    = 8'h32,
		opBne    = 8'h33,
		opBmi    = 8'h34,
		opBpl    = 8'h35,
		opBvc    = 8'h36,
		opBvs    = 8'h37,
		// Implied
		opCla    = 8'h40,
		opIna    = 8'h41,
		opDca    = 8'h42,
		opRol    = 8'h43,
		opRor    = 8'h44,
		opCpa    = 8'h45,
		opClc    = 8'h46,
		opSec    = 8'h47,
		opNop    = 8'h48,
		// Stack page
		opPha    = 8'h50,
		opPla    = 8'h51,
		opPhs    = 8'h52,
		opPls    = 8'h53,
		opHlt    = 8'h60
	} opcode;

	typedef enum logic [3:0] {
		aluPass, aluAdd, aluSub, aluAnd, aluOr, aluClear, aluInc,
		aluDec, aluRol, aluRor, aluCpl, aluClc, aluSec
	} aluOp;

	// Same byte seen raw on the stack and as flags in the core
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [1:0] rsvdHi;
			logic       n;
			logic       rsvd4;
			logic       v;
			logic       rsvd2;
			logic       z;
			logic       c;
		} flag;
	} statusWord;

endpackage

// File: ctrlPkg.sv
// ========================================
// Accumulator CPU control types
// FSM states and bus source selectors
// ========================================
package ctrlPkg;

	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stImm,
		stAdrLo,
		stAdrHi,
		stMemRead,
		stMemWrite,
		stPush,
		stPop,
		stHalt,
		stIllegal
	} cpuState;

	typedef enum logic [1:0] {
		adrPc,      // Program counter
		adrOperand, // Latched absolute address
		adrPush,    // stackPage:P
		adrPop      // stackPage:P-1
	} addrSrc;

	typedef enum logic {
		wrAcc,
		wrStatus
	} wrSrc;

endpackage

// File: aluCore.sv
// ========================================
// Accumulator ALU
// Arithmetic, logic and rotates with flags
// ========================================
`timescale 1ns/1ns

module aluCore (
	input  logic [7:0]        acc,
	input  logic [7:0]        operand,
	input  isaPkg::aluOp      op,
	input  isaPkg::statusWord flagsIn,
	output logic [7:0]        result,
	output isaPkg::statusWord flagsOut
);

	logic [8:0] sum;

	always_comb begin
		sum = 9'd0;
		result = acc;
		flagsOut = flagsIn;
		case (op)
			isaPkg::aluPass: result = operand;
			isaPkg::aluAdd: begin
				sum = {1'b0, acc} + {1'b0, operand};
				result = sum[7:0];
				flagsOut.flag.c = sum[8];
				flagsOut.flag.v = (acc[7] == operand[7]) && (sum[7] != acc[7]);
			end
			isaPkg::aluSub: begin
				sum = {1'b0, acc} - {1'b0, operand};
				result = sum[7:0];
				flagsOut.flag.c = sum[8]; // Borrow
				flagsOut.flag.v = (acc[7] != operand[7]) && (sum[7] != acc[7]);
			end
			isaPkg::aluAnd: result = acc & operand;
			isaPkg::aluOr: result = acc | operand;
			isaPkg::aluClear: result = 8'd0;
			isaPkg::aluInc: begin
				sum = {1'b0, acc} + 9'd1;
				result = sum[7:0];
				flagsOut.flag.c = sum[8];
			end
			isaPkg::aluDec: begin
				sum = {1'b0, acc} - 9'd1;
				result = sum[7:0];
				flagsOut.flag.c = sum[8];
			end
			// Rotates go through carry
			isaPkg::aluRol: begin
				result = {acc[6:0], flagsIn.flag.c};
				flagsOut.flag.c = acc[7];
			end
			isaPkg::aluRor: begin
				result = {flagsIn.flag.c, acc[7:1]};
				flagsOut.flag.c = acc[0];
			end
			isaPkg::aluCpl: result = ~acc;
			isaPkg::aluClc: flagsOut.flag.c = 1'b0;
			isaPkg::aluSec: flagsOut.flag.c = 1'b1;
			default: result = acc;
		endcase
		flagsOut.flag.z = (result == 8'd0);
		flagsOut.flag.n = result[7];
	end

endmodule

// File: accumulatorUnit.sv
// ========================================
// Accumulator datapath
// A and status registers, ALU, write data
// ========================================
`timescale 1ns/1ns

module accumulatorUnit (
	input  logic              CLK,
	input  logic              rstN,
	input  logic [7:0]        rdData,
	input  isaPkg::aluOp      aluOp,
	input  logic              accLoad,
	input  logic              flagLoad,
	input  ctrlPkg::wrSrc     wrSel,
	output isaPkg::statusWord flags,
	output logic [7:0]        wrData
);

	logic [7:0]        accReg;
	logic [7:0]        aluResult;
	isaPkg::statusWord statusReg;
	isaPkg::statusWord aluFlags;
	isaPkg::statusWord plsWord;

	aluCore uAlu (
		.acc      (accReg),
		.operand  (rdData),
		.op       (aluOp),
		.flagsIn  (statusReg),
		.result   (aluResult),
		.flagsOut (aluFlags)
	);

	// Popped status byte, unused bits forced to zero
	always_comb begin
		plsWord = '0;
		plsWord.flag.c = rdData[0];
		plsWord.flag.z = rdData[1];
		plsWord.flag.v = rdData[3];
		plsWord.flag.n = rdData[5];
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			accReg <= 8'd0;
			statusReg <= '0;
		end else if (accLoad) begin
			accReg <= aluResult;
			statusReg <= aluFlags;
		end else if (flagLoad) begin
			statusReg.raw <= plsWord.raw; // PLS
		end
	end

	assign flags = statusReg;
	assign wrData = (wrSel == ctrlPkg::wrStatus) ? statusReg.raw : accReg;

endmodule

// File: addressUnit.sv
// ========================================
// Address datapath
// PC, operand address, stack pointer and
// the address bus multiplexer
// ========================================
`timescale 1ns/1ns

module addressUnit #(
	parameter logic [15:0] resetVector = 16'h0000,
	parameter logic [7:0]  stackPage   = 8'hFF
) (
	input  logic             CLK,
	input  logic             rstN,
	input  logic [7:0]       rdData,
	input  ctrlPkg::addrSrc  addrSel,
	input  logic             pcStep,
	input  logic             pcLoad,
	input  logic             branchTaken,
	input  logic             adrLoLoad,
	input  logic             adrHiLoad,
	input  logic             spPush,
	input  logic             spPop,
	output logic [15:0]      address
);

	logic [15:0] pc;
	logic [15:0] operandAdr;
	logic [7:0]  adrLo;
	logic [7:0]  sp;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= resetVector;
			sp <= 8'd0;
		end else begin
			if (pcLoad)
				pc <= {rdData, adrLo}; // JMP
			else if (branchTaken)
				pc <= pc + 16'd1 + {{8{rdData[7]}}, rdData};
			else if (pcStep)
				pc <= pc + 16'd1;

			if (spPush)
				sp <= sp + 8'd1;
			else if (spPop)
				sp <= sp - 8'd1;
		end
	end

	// Low byte waits here until the high byte arrives
	always_ff @(posedge CLK) begin
		if (adrLoLoad)
			adrLo <= rdData;
		if (adrHiLoad)
			operandAdr <= {rdData, adrLo};
	end

	always_comb begin
		case (addrSel)
			ctrlPkg::adrPc:      address = pc;
			ctrlPkg::adrOperand: address = operandAdr;
			ctrlPkg::adrPush:    address = {stackPage, sp};
			ctrlPkg::adrPop:     address = {stackPage, sp - 8'd1};
			default:             address = pc;
		endcase
	end

	// Control never asks for a jump and a branch in one cycle
	pcSourceOne: assert property (@(posedge CLK) disable iff (!rstN)
		!(pcLoad && branchTaken));

endmodule

// File: cpuControl.sv
// ========================================
// Accumulator CPU control
// Opcode latch, state FSM, bus strobes and
// branch decision
// ========================================
`timescale 1ns/1ns

module cpuControl (
	input  logic              CLK,
	input  logic              rstN,
	input  logic [7:0]        rdData,
	input  isaPkg::statusWord flags,
	output logic              fetch,
	output logic              rdEn,
	output logic              wrEn,
	output logic              halt,
	output isaPkg::aluOp      aluOp,
	output logic              accLoad,
	output logic              flagLoad,
	output ctrlPkg::wrSrc     wrSel,
	output ctrlPkg::addrSrc   addrSel,
	output logic              pcStep,
	output logic              pcLoad,
	output logic              branchTaken,
	output logic              adrLoLoad,
	output logic              adrHiLoad,
	output logic              spPush,
	output logic              spPop
);

	ctrlPkg::cpuState state, nextState;
	isaPkg::opcode    ir;
	logic             isBranch;
	logic             condMet;

	// Reset waits in the fetch of the reset vector
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			state <= ctrlPkg::stFetch;
			ir <= isaPkg::opNop;
			halt <= 1'b0;
		end else begin
			state <= nextState;
			if (state == ctrlPkg::stFetch)
				ir <= isaPkg::opcode'(rdData);
			if (nextState == ctrlPkg::stHalt)
				halt <= 1'b1;
			else if (nextState == ctrlPkg::stIllegal)
				halt <= ~halt; // Blinks on undefined opcode
			else
				halt <= 1'b0;
		end
	end

	always_comb begin
		case (ir)
			isaPkg::opAddImm, isaPkg::opAddAbs: aluOp = isaPkg::aluAdd;
			isaPkg::opSubImm, isaPkg::opSubAbs: aluOp = isaPkg::aluSub;
			isaPkg::opAndImm, isaPkg::opAndAbs: aluOp = isaPkg::aluAnd;
			isaPkg::opOraImm, isaPkg::opOraAbs: aluOp = isaPkg::aluOr;
			isaPkg::opCla: aluOp = isaPkg::aluClear;
			isaPkg::opIna: aluOp = isaPkg::aluInc;
			isaPkg::opDca: aluOp = isaPkg::aluDec;
			isaPkg::opRol: aluOp = isaPkg::aluRol;
			isaPkg::opRor: aluOp = isaPkg::aluRor;
			isaPkg::opCpa: aluOp = isaPkg::aluCpl;
			isaPkg::opClc: aluOp = isaPkg::aluClc;
			isaPkg::opSec: aluOp = isaPkg::aluSec;
			default: aluOp = isaPkg::aluPass; // LDA, PLA
		endcase
	end

	always_comb begin
		isBranch = 1'b1;
		case (ir)
			isaPkg::opBcc: condMet = !flags.flag.c;
			isaPkg::opBcs: condMet = flags.flag.c;
			isaPkg::opBeq: condMet = flags.flag.z;
			isaPkg::opBne: condMet = !flags.flag.z;
			isaPkg::opBmi: condMet = flags.flag.n;
			isaPkg::opBpl: condMet = !flags.flag.n;
			isaPkg::opBvc: condMet = !flags.flag.v;
			isaPkg::opBvs: condMet = flags.flag.v;
			default: begin
				isBranch = 1'b0;
				condMet = 1'b0;
			end
		endcase
	end

	always_comb begin
		nextState = state;
		fetch = 1'b0;
		rdEn = 1'b0;
		wrEn = 1'b0;
		accLoad = 1'b0;
		flagLoad = 1'b0;
		wrSel = ctrlPkg::wrAcc;
		addrSel = ctrlPkg::adrPc;
		pcStep = 1'b0;
		pcLoad = 1'b0;
		branchTaken = 1'b0;
		adrLoLoad = 1'b0;
		adrHiLoad = 1'b0;
		spPush = 1'b0;
		spPop = 1'b0;
		case (state)
			ctrlPkg::stFetch: begin
				fetch = 1'b1;
				rdEn = 1'b1;
				pcStep = 1'b1;
				nextState = ctrlPkg::stDecode;
			end
			ctrlPkg::stDecode: begin
				case (ir)
					isaPkg::opLdaImm, isaPkg::opAddImm, isaPkg::opSubImm,
					isaPkg::opAndImm, isaPkg::opOraImm,
					isaPkg::opBcc, isaPkg::opBcs, isaPkg::opBeq, isaPkg::opBne,
					isaPkg::opBmi, isaPkg::opBpl, isaPkg::opBvc, isaPkg::opBvs:
						nextState = ctrlPkg::stImm;
					isaPkg::opLdaAbs, isaPkg::opAddAbs, isaPkg::opSubAbs,
					isaPkg::opAndAbs, isaPkg::opOraAbs, isaPkg::opStaAbs,
					isaPkg::opJmpAbs:
						nextState = ctrlPkg::stAdrLo;
					isaPkg::opCla, isaPkg::opIna, isaPkg::opDca, isaPkg::opRol,
					isaPkg::opRor, isaPkg::opCpa, isaPkg::opClc, isaPkg::opSec: begin
						accLoad = 1'b1; // Implied op completes here
						nextState = ctrlPkg::stFetch;
					end
					isaPkg::opNop: nextState = ctrlPkg::stFetch;
					isaPkg::opPha, isaPkg::opPhs: nextState = ctrlPkg::stPush;
					isaPkg::opPla, isaPkg::opPls: nextState = ctrlPkg::stPop;
					isaPkg::opHlt: nextState = ctrlPkg::stHalt;
					default: nextState = ctrlPkg::stIllegal;
				endcase
			end
			ctrlPkg::stImm: begin
				rdEn = 1'b1;
				pcStep = 1'b1;
				if (isBranch)
					branchTaken = condMet;
				else
					accLoad = 1'b1;
				nextState = ctrlPkg::stFetch;
			end
			ctrlPkg::stAdrLo: begin
				rdEn = 1'b1;
				pcStep = 1'b1;
				adrLoLoad = 1'b1;
				nextState = ctrlPkg::stAdrHi;
			end
			ctrlPkg::stAdrHi: begin
				rdEn = 1'b1;
				if (ir == isaPkg::opJmpAbs) begin
					pcLoad = 1'b1;
					nextState = ctrlPkg::stFetch;
				end else begin
					pcStep = 1'b1;
					adrHiLoad = 1'b1;
					nextState = (ir == isaPkg::opStaAbs) ? ctrlPkg::stMemWrite
						: ctrlPkg::stMemRead;
				end
			end
			ctrlPkg::stMemRead: begin
				rdEn = 1'b1;
				addrSel = ctrlPkg::adrOperand;
				accLoad = 1'b1;
				nextState = ctrlPkg::stFetch;
			end
			ctrlPkg::stMemWrite: begin
				wrEn = 1'b1;
				addrSel = ctrlPkg::adrOperand;
				nextState = ctrlPkg::stFetch;
			end
			ctrlPkg::stPush: begin
				wrEn = 1'b1;
				addrSel = ctrlPkg::adrPush;
				wrSel = (ir == isaPkg::opPhs) ? ctrlPkg::wrStatus : ctrlPkg::wrAcc;
				spPush = 1'b1;
				nextState = ctrlPkg::stFetch;
			end
			ctrlPkg::stPop: begin
				rdEn = 1'b1;
				addrSel = ctrlPkg::adrPop;
				spPop = 1'b1;
				if (ir == isaPkg::opPls)
					flagLoad = 1'b1;
				else
					accLoad = 1'b1;
				nextState = ctrlPkg::stFetch;
			end
			ctrlPkg::stHalt: nextState = ctrlPkg::stHalt;
			default: nextState = ctrlPkg::stIllegal;
		endcase
		if (!rstN) begin // Bus idle while reset holds
			fetch = 1'b0;
			rdEn = 1'b0;
		end
	end

	busExclusive: assert property (@(posedge CLK) disable iff (!rstN)
		!(rdEn && wrEn));

	fetchReads: assert property (@(posedge CLK) disable iff (!rstN)
		fetch |-> rdEn);

endmodule

// File: cpuTop.sv
// ========================================
// Accumulator CPU top level
// Control FSM joined to both datapaths
// ========================================
`timescale 1ns/1ns

module cpuTop #(
	parameter logic [15:0] resetVector = 16'h0000,
	parameter logic [7:0]  stackPage   = 8'hFF
) (
	input  logic        CLK,
	input  logic        rstN,
	input  logic [7:0]  rdData,
	output logic [15:0] address,
	output logic [7:0]  wrData,
	output logic        rdEn,
	output logic        wrEn,
	output logic        fetch,
	output logic        halt
);

	isaPkg::statusWord flags;
	isaPkg::aluOp      aluOp;
	ctrlPkg::wrSrc     wrSel;
	ctrlPkg::addrSrc   addrSel;
	logic              accLoad, flagLoad;
	logic              pcStep, pcLoad, branchTaken;
	logic              adrLoLoad, adrHiLoad, spPush, spPop;

	cpuControl uControl (
		.CLK (CLK), .rstN (rstN), .rdData (rdData), .flags (flags),
		.fetch (fetch), .rdEn (rdEn), .wrEn (wrEn), .halt (halt),
		.aluOp (aluOp), .accLoad (accLoad), .flagLoad (flagLoad),
		.wrSel (wrSel), .addrSel (addrSel),
		.pcStep (pcStep), .pcLoad (pcLoad), .branchTaken (branchTaken),
		.adrLoLoad (adrLoLoad), .adrHiLoad (adrHiLoad),
		.spPush (spPush), .spPop (spPop)
	);

	accumulatorUnit uAccum (
		.CLK (CLK), .rstN (rstN), .rdData (rdData), .aluOp (aluOp),
		.accLoad (accLoad), .flagLoad (flagLoad), .wrSel (wrSel),
		.flags (flags), .wrData (wrData)
	);

	addressUnit #(
		.resetVector (resetVector),
		.stackPage   (stackPage)
	) uAddress (
		.CLK (CLK), .rstN (rstN), .rdData (rdData), .addrSel (addrSel),
		.pcStep (pcStep), .pcLoad (pcLoad), .branchTaken (branchTaken),
		.adrLoLoad (adrLoLoad), .adrHiLoad (adrHiLoad),
		.spPush (spPush), .spPop (spPop), .address (address)
	);

endmodule

// File: cpuTb.sv
// ========================================
// Accumulator CPU testbench
// Runs a table of small programs against a
// reference model and checks every store
// ========================================
`timescale 1ns/1ns

module cpuTb;

	localparam logic [15:0] resetVector = 16'h0200;
	localparam logic [7:0]  stackPage   = 8'hFF;
	localparam int numRows    = 9;
	localparam int progLen    = 96;
	localparam int maxStores  = 20;
	localparam int runLimit   = 400;
	localparam int holdCycles = 20;

	logic        CLK;
	logic        rstN;
	logic [7:0]  rdData;
	logic [15:0] address;
	logic [7:0]  wrData;
	logic        rdEn, wrEn, fetch, halt;

	logic [7:0]  mem    [0:65535];
	logic [7:0]  refMem [0:65535]; // Model's own copy
	logic [15:0] wrAdrLog [$];
	logic [7:0]  wrValLog [$];

	// Program table with the expected stores of each row
	logic [7:0]  prog       [numRows][progLen];
	logic [15:0] expAdr     [numRows][maxStores];
	logic [7:0]  expVal     [numRows][maxStores];
	int          expCount   [numRows];
	logic        expIllegal [numRows];

	integer seed;
	int     pos;
	int     curRow;

	cpuTop #(
		.resetVector (resetVector),
		.stackPage   (stackPage)
	) u_dut (
		.CLK (CLK), .rstN (rstN), .rdData (rdData), .address (address),
		.wrData (wrData), .rdEn (rdEn), .wrEn (wrEn), .fetch (fetch), .halt (halt)
	);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	assign rdData = (rdEn === 1'b1) ? mem[address] : 8'h00;

	always @(posedge CLK) begin
		if (wrEn === 1'b1) begin
			mem[address] <= wrData;
			wrAdrLog.push_back(address);
			wrValLog.push_back(wrData);
		end
	end

	task automatic compareValue(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("CHECK FAILED time %0t: %s = %h, expected %h", $time, name, got, want);
			$display("Done: errors found");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	task automatic stopOnTimeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("Done: errors found");
		$fatal(1, "Wait loop timed out");
	endtask

	function automatic logic [7:0] randomByte();
		randomByte = $random(seed);
	endfunction

	task automatic putByte(input logic [7:0] b);
		prog[curRow][pos] = b;
		pos++;
	endtask

	task automatic immOp(input isaPkg::opcode op, input logic [7:0] b);
		putByte(op);
		putByte(b);
	endtask

	task automatic withAddress(input isaPkg::opcode op, input logic [15:0] adr);
		putByte(op);
		putByte(adr[7:0]); // Low byte first
		putByte(adr[15:8]);
	endtask

	function automatic int operandBytes(input isaPkg::opcode op);
		case (op)
			isaPkg::opLdaImm, isaPkg::opAddImm, isaPkg::opSubImm, isaPkg::opAndImm,
			isaPkg::opOraImm, isaPkg::opBcc, isaPkg::opBcs, isaPkg::opBeq, isaPkg::opBne,
			isaPkg::opBmi, isaPkg::opBpl, isaPkg::opBvc, isaPkg::opBvs:
				operandBytes = 1;
			isaPkg::opLdaAbs, isaPkg::opAddAbs, isaPkg::opSubAbs, isaPkg::opAndAbs,
			isaPkg::opOraAbs, isaPkg::opStaAbs, isaPkg::opJmpAbs:
				operandBytes = 2;
			default: operandBytes = 0;
		endcase
	endfunction

	task automatic loadImage(input int row);
		int i;
		logic [15:0] adr;
		for (i = 0; i < 65536; i++) begin
			adr = i[15:0];
			mem[adr] = adr[7:0] ^ (adr[15:8] * 8'h3B) ^ 8'h5A;
			refMem[adr] = mem[adr];
		end
		for (i = 0; i < progLen; i++) begin
			adr = resetVector + i[15:0];
			mem[adr] = prog[row][i];
			refMem[adr] = prog[row][i];
		end
	endtask

	task automatic expectWrite(input int row, input logic [15:0] adr, input logic [7:0] val);
		refMem[adr] = val;
		if (expCount[row] < maxStores) begin
			expAdr[row][expCount[row]] = adr;
			expVal[row][expCount[row]] = val;
		end
		expCount[row]++;
	endtask

	// Instruction level model of the ISA
	task automatic runModel(input int row);
		isaPkg::opcode op;
		logic [15:0] pc, ea, offset;
		logic [8:0]  sum;
		logic [7:0]  a, b, sp;
		logic        c, z, v, n, ended, accOp;
		int          steps;
		int          sRes;
		pc = resetVector;
		a = 8'd0;
		sp = 8'd0;
		{c, z, v, n} = 4'd0;
		ended = 1'b0;
		steps = 0;
		expCount[row] = 0;
		expIllegal[row] = 1'b0;
		while (!ended && steps < 200) begin
			op = isaPkg::opcode'(refMem[pc]);
			pc = pc + 16'd1;
			steps++;
			b = refMem[pc];
			ea = {refMem[pc + 16'd1], refMem[pc]};
			offset = {{8{b[7]}}, b};
			pc = pc + 16'(operandBytes(op));
			if (operandBytes(op) == 2)
				b = refMem[ea];
			accOp = 1'b1;
			case (op)
				isaPkg::opLdaImm, isaPkg::opLdaAbs: a = b;
				isaPkg::opAddImm, isaPkg::opAddAbs: begin
					sum = {1'b0, a} + {1'b0, b};
					sRes = $signed(a) + $signed(b);
					v = (sRes > 127) || (sRes < -128); // Signed result leaves the byte
					c = sum[8];
					a = sum[7:0];
				end
				isaPkg::opSubImm, isaPkg::opSubAbs: begin
					sum = {1'b0, a} - {1'b0, b};
					sRes = $signed(a) - $signed(b);
					v = (sRes > 127) || (sRes < -128);
					c = (a < b); // Borrow
					a = sum[7:0];
				end
				isaPkg::opAndImm, isaPkg::opAndAbs: a = a & b;
				isaPkg::opOraImm, isaPkg::opOraAbs: a = a | b;
				isaPkg::opCla: a = 8'd0;
				isaPkg::opIna: begin
					c = (a == 8'hFF);
					a = a + 8'd1;
				end
				isaPkg::opDca: begin
					c = (a == 8'h00);
					a = a - 8'd1;
				end
				isaPkg::opRol: {c, a} = {a, c};
				isaPkg::opRor: {a, c} = {c, a};
				isaPkg::opCpa: a = ~a;
				isaPkg::opClc: c = 1'b0;
				isaPkg::opSec: c = 1'b1;
				isaPkg::opPla: begin
					sp = sp - 8'd1;
					a = refMem[{stackPage, sp}];
				end
				default: accOp = 1'b0;
			endcase
			if (accOp) begin
				z = (a == 8'd0);
				n = a[7];
			end
			case (op)
				isaPkg::opStaAbs: expectWrite(row, ea, a);
				isaPkg::opJmpAbs: pc = ea;
				isaPkg::opBcc: if (!c) pc = pc + offset;
				isaPkg::opBcs: if (c) pc = pc + offset;
				isaPkg::opBeq: if (z) pc = pc + offset;
				isaPkg::opBne: if (!z) pc = pc + offset;
				isaPkg::opBmi: if (n) pc = pc + offset;
				isaPkg::opBpl: if (!n) pc = pc + offset;
				isaPkg::opBvc: if (!v) pc = pc + offset;
				isaPkg::opBvs: if (v) pc = pc + offset;
				isaPkg::opPha: begin
					expectWrite(row, {stackPage, sp}, a);
					sp = sp + 8'd1;
				end
				isaPkg::opPhs: begin
					expectWrite(row, {stackPage, sp}, {2'b00, n, 1'b0, v, 1'b0, z, c});
					sp = sp + 8'd1;
				end
				isaPkg::opPls: begin
					sp = sp - 8'd1;
					b = refMem[{stackPage, sp}];
					{n, v, z, c} = {b[5], b[3], b[1], b[0]};
				end
				isaPkg::opNop: ;
				isaPkg::opHlt: ended = 1'b1;
				default: begin
					if (!accOp) begin
						ended = 1'b1;
						expIllegal[row] = 1'b1;
					end
				end
			endcase
		end
	endtask

	task automatic buildTable();
		int row, k;
		logic [7:0]    setA [4];
		logic [7:0]    setB [4];
		isaPkg::opcode branchOps [8];
		setA = '{8'h80, 8'h01, 8'hF0, randomByte()};
		setB = '{8'h80, 8'h01, 8'h01, randomByte()};
		branchOps = '{isaPkg::opBcc, isaPkg::opBcs, isaPkg::opBeq, isaPkg::opBne,
			isaPkg::opBmi, isaPkg::opBpl, isaPkg::opBvc, isaPkg::opBvs};
		for (row = 0; row < numRows; row++)
			for (k = 0; k < progLen; k++)
				prog[row][k] = 8'h00;
		// Immediate and implied operations
		curRow = 0;
		pos = 0;
		immOp(isaPkg::opLdaImm, randomByte());
		withAddress(isaPkg::opStaAbs, 16'h0500);
		immOp(isaPkg::opAddImm, randomByte());
		withAddress(isaPkg::opStaAbs, 16'h0501);
		immOp(isaPkg::opSubImm, randomByte());
		withAddress(isaPkg::opStaAbs, 16'h0502);
		immOp(isaPkg::opAndImm, randomByte());
		immOp(isaPkg::opOraImm, randomByte());
		withAddress(isaPkg::opStaAbs, 16'h0503);
		putByte(isaPkg::opIna);
		putByte(isaPkg::opRol);
		withAddress(isaPkg::opStaAbs, 16'h0504);
		putByte(isaPkg::opDca);
		putByte(isaPkg::opRor);
		putByte(isaPkg::opCpa);
		withAddress(isaPkg::opStaAbs, 16'h0505);
		putByte(isaPkg::opClc);
		putByte(isaPkg::opRol);
		putByte(isaPkg::opSec);
		putByte(isaPkg::opRor);
		withAddress(isaPkg::opStaAbs, 16'h0506);
		putByte(isaPkg::opCla);
		putByte(isaPkg::opNop);
		putByte(isaPkg::opPhs);
		withAddress(isaPkg::opStaAbs, 16'h0507);
		putByte(isaPkg::opHlt);
		// Absolute operands from the data page
		curRow = 1;
		pos = 0;
		withAddress(isaPkg::opLdaAbs, {8'h03, randomByte()});
		withAddress(isaPkg::opAddAbs, {8'h03, randomByte()});
		withAddress(isaPkg::opStaAbs, 16'h0510);
		withAddress(isaPkg::opSubAbs, {8'h03, randomByte()});
		withAddress(isaPkg::opStaAbs, 16'h0511);
		withAddress(isaPkg::opAndAbs, {8'h03, randomByte()});
		withAddress(isaPkg::opOraAbs, {8'h03, randomByte()});
		withAddress(isaPkg::opStaAbs, 16'h0512);
		putByte(isaPkg::opPhs);
		putByte(isaPkg::opHlt);
		// Every branch under four flag setups, taken path skips INA
		for (row = 2; row < 6; row++) begin
			curRow = row;
			pos = 0;
			for (k = 0; k < 8; k++) begin
				immOp(isaPkg::opLdaImm, setA[row - 2]);
				immOp(isaPkg::opAddImm, setB[row - 2]);
				putByte(isaPkg::opPhs);
				immOp(branchOps[k], 8'h01);
				putByte(isaPkg::opIna);
				withAddress(isaPkg::opStaAbs, 16'h0600 + 16'(row * 16 + k));
			end
			putByte(isaPkg::opHlt);
		end
		// Stack push, pop and status restore
		curRow = 6;
		pos = 0;
		immOp(isaPkg::opLdaImm, randomByte());
		putByte(isaPkg::opPha);
		immOp(isaPkg::opLdaImm, randomByte());
		immOp(isaPkg::opAddImm, randomByte());
		putByte(isaPkg::opPhs);
		putByte(isaPkg::opCla);
		putByte(isaPkg::opSec);
		putByte(isaPkg::opPls);
		putByte(isaPkg::opPhs);
		putByte(isaPkg::opPls);
		putByte(isaPkg::opCla);
		putByte(isaPkg::opPla);
		withAddress(isaPkg::opStaAbs, 16'h0520);
		putByte(isaPkg::opHlt);
		// JMP over a store that must not happen
		curRow = 7;
		pos = 0;
		immOp(isaPkg::opLdaImm, randomByte());
		withAddress(isaPkg::opJmpAbs, resetVector + 16'h0040);
		withAddress(isaPkg::opStaAbs, 16'h0700);
		putByte(isaPkg::opHlt);
		pos = 'h40;
		withAddress(isaPkg::opStaAbs, 16'h0701);
		putByte(isaPkg::opHlt);
		// Undefined opcode after one store
		curRow = 8;
		pos = 0;
		immOp(isaPkg::opLdaImm, randomByte());
		withAddress(isaPkg::opStaAbs, 16'h0702);
		putByte(8'hFF);
		for (row = 0; row < numRows; row++) begin
			loadImage(row);
			runModel(row);
		end
	endtask

	task automatic applyRow(input int row);
		int   i;
		int   count;
		logic prevHalt;
		@(posedge CLK);
		#2 rstN = 1'b0;
		loadImage(row);
		for (i = 0; i < 8; i++) begin
			@(negedge CLK);
			if (i > 0) begin // First reset edge still ahead
				compareValue("rdEn", rdEn, 1'b0);
				compareValue("wrEn", wrEn, 1'b0);
				compareValue("halt", halt, 1'b0);
			end
		end
		wrAdrLog.delete();
		wrValLog.delete();
		@(posedge CLK);
		#2 rstN = 1'b1;
		@(negedge CLK);
		compareValue("fetch", fetch, 1'b1); // First cycle out of reset
		compareValue("address", address, resetVector);
		compareValue("rdEn", rdEn, 1'b1);
		count = 0;
		while (halt !== 1'b1) begin
			@(negedge CLK);
			count++;
			if (count > runLimit)
				stopOnTimeout($sformatf("row %0d never raised halt", row));
		end
		for (i = 0; i < holdCycles; i++) begin
			prevHalt = halt;
			@(negedge CLK);
			compareValue("wrEn", wrEn, 1'b0);
			if (expIllegal[row]) begin
				compareValue("halt", halt, !prevHalt); // Blinking
			end else begin
				compareValue("halt", halt, 1'b1);
				compareValue("rdEn", rdEn, 1'b0);
			end
		end
		compareValue($sformatf("row %0d store count", row), wrAdrLog.size(), expCount[row]);
		for (i = 0; i < expCount[row]; i++) begin
			compareValue($sformatf("row %0d address[%0d]", row, i), wrAdrLog[i], expAdr[row][i]);
			compareValue($sformatf("row %0d wrData[%0d]", row, i), wrValLog[i], expVal[row][i]);
		end
	endtask

	initial begin
		int row;
		rstN = 1'b0;
		seed = 32'hc;
		buildTable();
		for (row = 0; row < numRows; row++)
			applyRow(row);
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: src.f
isaPkg.sv
ctrlPkg.sv
aluCore.sv
accumulatorUnit.sv
addressUnit.sv
cpuControl.sv
cpuTop.sv
cpuTb.sv

// File: Bender.yml
package:
  name: acc_cpu

sources:
  - files:
      - isaPkg.sv
      - ctrlPkg.sv
      - aluCore.sv
      - accumulatorUnit.sv
      - addressUnit.sv
      - cpuControl.sv
      - cpuTop.sv
  - target: test
    files:
      - cpuTb.sv
